//--- uart_pkg.sv
package uart_pkg;

   // Register offsets from the base address of the block.
   localparam logic [7:0] addr_data     = 8'd0;
   localparam logic [7:0] addr_control  = 8'd1;
   localparam logic [7:0] addr_status   = 8'd2;
   localparam logic [7:0] addr_irq_mask = 8'd3;
   localparam logic [7:0] addr_irq      = 8'd4;
   localparam logic [7:0] addr_div_lo   = 8'd5;
   localparam logic [7:0] addr_div_hi   = 8'd6;

   localparam int fifo_depth = 16;

   // Timer ticks per serial bit.
   localparam int oversample = 16;

   typedef struct packed {
      logic [6:0] reserved;
      logic       enable;
   } control_t;

   typedef struct packed {
      logic [1:0] zero;
      logic       tx_full;
      logic       tx_half;
      logic       tx_present;
      logic       rx_full;
      logic       rx_half;
      logic       rx_present;
   } status_t;

   // Shared layout of the interrupt mask and pending registers.
   typedef struct packed {
      logic frame_error;
      logic tx_empty;
      logic rx_ready;
   } irq_t;

   typedef struct packed {
      logic       frame_error;
      logic [7:0] data;
   } rx_frame_t;

endpackage

//--- uart_regs.sv
`timescale 1ns/10ps

module uart_regs #(
   parameter logic [7:0] base_address = 8'h00
) (
   input  logic                clk,
   input  logic                rst,
   input  logic [7:0]          port_id,
   input  logic [7:0]          data_in,
   input  logic                read_strobe,
   input  logic                write_strobe,
   output logic [7:0]          data_out,
   output logic                interrupt,
   output logic                tx_push,
   output logic [7:0]          tx_byte,
   output logic                rx_pop,
   input  uart_pkg::rx_frame_t rx_head,
   input  uart_pkg::status_t   status,
   input  logic                frame_error,
   output logic                enable,
   output logic [15:0]         clock_divide
);

   uart_pkg::control_t control;
   uart_pkg::irq_t     irq_mask;
   uart_pkg::irq_t     irq_pending;
   uart_pkg::irq_t     irq_set;
   uart_pkg::irq_t     irq_clear;
   logic [7:0]         offset;
   logic               tx_present_d;

   // Offsets wrap modulo 256, so only base..base+6 land on a register.
   assign offset = port_id - base_address;
   assign enable = control.enable;

   always_comb begin
      irq_set.rx_ready    = status.rx_present;
      irq_set.tx_empty    = tx_present_d && !status.tx_present;
      irq_set.frame_error = frame_error;
   end

   assign irq_clear = (write_strobe && offset == uart_pkg::addr_irq) ?
                      uart_pkg::irq_t'(data_in[2:0]) : uart_pkg::irq_t'(3'b000);

   always_ff @(posedge clk) begin
      if (rst) begin
         control      <= '0;
         irq_mask     <= '0;
         clock_divide <= '0;
         tx_push      <= 1'b0;
      end else begin
         tx_push <= write_strobe && (offset == uart_pkg::addr_data);
         if (write_strobe) begin
            case (offset)
               uart_pkg::addr_control:  control <= uart_pkg::control_t'(data_in);
               uart_pkg::addr_irq_mask: irq_mask <= uart_pkg::irq_t'(data_in[2:0]);
               uart_pkg::addr_div_lo:   clock_divide[7:0] <= data_in;
               uart_pkg::addr_div_hi:   clock_divide[15:8] <= data_in;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (write_strobe) begin
         tx_byte <= data_in;
      end
   end

   // An empty receive FIFO reads as zero.
   always_ff @(posedge clk) begin
      if (rst) begin
         data_out <= '0;
         rx_pop   <= 1'b0;
      end else begin
         rx_pop <= read_strobe && (offset == uart_pkg::addr_data);
         if (read_strobe) begin
            case (offset)
               uart_pkg::addr_data:
                  data_out <= status.rx_present ? rx_head.data : 8'h00;
               uart_pkg::addr_control:  data_out <= control;
               uart_pkg::addr_status:   data_out <= status;
               uart_pkg::addr_irq_mask: data_out <= {5'b00000, irq_mask};
               uart_pkg::addr_irq:      data_out <= {5'b00000, irq_pending};
               uart_pkg::addr_div_lo:   data_out <= clock_divide[7:0];
               uart_pkg::addr_div_hi:   data_out <= clock_divide[15:8];
               default:                 data_out <= 8'h00;
            endcase
         end
      end
   end

   // A new event wins over a clear written in the same cycle.
   always_ff @(posedge clk) begin
      if (rst) begin
         irq_pending  <= '0;
         tx_present_d <= 1'b0;
         interrupt    <= 1'b0;
      end else begin
         irq_pending  <= (irq_pending & ~irq_clear) | irq_set;
         tx_present_d <= status.tx_present;
         interrupt    <= |(irq_pending & irq_mask);
      end
   end

   a_strobes_exclusive: assert property (
      @(posedge clk) disable iff (rst) !(read_strobe && write_strobe)
   ) else $error("read_strobe and write_strobe asserted together");

endmodule

//--- uart_baud_timer.sv
`timescale 1ns/10ps

module uart_baud_timer (
   input  logic        clk,
   input  logic        rst,
   input  logic        enable,
   input  logic [15:0] clock_divide,
   output logic        tick
);

   logic [15:0] count;

   // The count runs from clock_divide down to zero, so a tick comes
   // every clock_divide+1 cycles.
   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
         tick  <= 1'b0;
      end else if (!enable) begin
         count <= clock_divide;
         tick  <= 1'b0;
      end else if (count == 16'd0) begin
         count <= clock_divide;
         tick  <= 1'b1;
      end else begin
         count <= count - 16'd1;
         tick  <= 1'b0;
      end
   end

endmodule

//--- uart_fifo.sv
`timescale 1ns/10ps

module uart_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = uart_pkg::fifo_depth
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     push,
   input  payload_t wdata,
   input  logic     pop,
   output payload_t rdata,
   output logic     present,
   output logic     half,
   output logic     full
);

   localparam int aw = $clog2(depth);
   localparam int cw = $clog2(depth + 1);

   payload_t      mem [depth];
   logic [aw-1:0] wr_ptr;
   logic [aw-1:0] rd_ptr;
   logic [cw-1:0] count;
   logic          do_push;
   logic          do_pop;

   assign do_pop  = pop && present;
   // A full FIFO still takes a push when the head leaves in the same cycle.
   assign do_push = push && (!full || do_pop);

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign rdata   = mem[rd_ptr];
   assign present = (count != '0);
   assign half    = (count >= cw'(depth / 2));
   assign full    = (count == cw'(depth));

   a_no_overflow: assert property (
      @(posedge clk) disable iff (rst) (push && full) |-> pop
   ) else $error("push to a full FIFO without a pop, item dropped");

endmodule

//--- uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
   input  logic       clk,
   input  logic       rst,
   input  logic       tick,
   input  logic       tx_present,
   input  logic [7:0] tx_byte,
   output logic       tx_pop,
   output logic       txd
);

   localparam int tw = $clog2(uart_pkg::oversample);

   typedef enum logic [1:0] {idle, start, data, stop} state_t;

   state_t        state;
   logic [tw-1:0] tick_cnt;
   logic [2:0]    bit_cnt;
   logic [7:0]    shift;
   logic          bit_done;

   assign bit_done = tick && (tick_cnt == tw'(uart_pkg::oversample - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= idle;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         tx_pop   <= 1'b0;
         txd      <= 1'b1;
      end else begin
         tx_pop <= 1'b0;
         if (state != idle && tick) begin
            tick_cnt <= bit_done ? '0 : tick_cnt + 1'b1;
         end
         case (state)
            idle: begin
               if (tick && tx_present) begin
                  state    <= start;
                  tx_pop   <= 1'b1;
                  shift    <= tx_byte;
                  tick_cnt <= '0;
                  txd      <= 1'b0;
               end
            end
            start: begin
               if (bit_done) begin
                  state   <= data;
                  bit_cnt <= '0;
                  txd     <= shift[0];
                  shift   <= shift >> 1;
               end
            end
            data: begin
               if (bit_done) begin
                  if (bit_cnt == 3'd7) begin
                     state <= stop;
                     txd   <= 1'b1;
                  end else begin
                     bit_cnt <= bit_cnt + 3'd1;
                     txd     <= shift[0];
                     shift   <= shift >> 1;
                  end
               end
            end
            stop: begin
               // Next byte follows straight on, without an idle bit.
               if (bit_done) begin
                  if (tx_present) begin
                     state  <= start;
                     tx_pop <= 1'b1;
                     shift  <= tx_byte;
                     txd    <= 1'b0;
                  end else begin
                     state <= idle;
                  end
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

//--- uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
   input  logic                clk,
   input  logic                rst,
   input  logic                tick,
   input  logic                enable,
   input  logic                rxd,
   output logic                rx_push,
   output uart_pkg::rx_frame_t rx_frame,
   output logic                frame_error
);

   localparam int tw = $clog2(uart_pkg::oversample);

   typedef enum logic [1:0] {idle, start, data, stop} state_t;

   state_t        state;
   logic          rxd_meta;
   logic          rxd_sync;
   logic [tw-1:0] tick_cnt;
   logic [2:0]    bit_cnt;
   logic [7:0]    shift;
   logic          mid_start;
   logic          mid_bit;

   // Start is rechecked half a bit in; later samples then fall at mid-bit.
   assign mid_start = tick && (tick_cnt == tw'(uart_pkg::oversample / 2 - 1));
   assign mid_bit   = tick && (tick_cnt == tw'(uart_pkg::oversample - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= idle;
         tick_cnt    <= '0;
         bit_cnt     <= '0;
         rx_push     <= 1'b0;
         frame_error <= 1'b0;
      end else begin
         rx_push     <= 1'b0;
         frame_error <= 1'b0;
         if (state != idle && tick) begin
            tick_cnt <= tick_cnt + 1'b1;
         end
         if (!enable) begin
            state <= idle;
         end else begin
            case (state)
               idle: begin
                  if (tick && !rxd_sync) begin
                     state    <= start;
                     tick_cnt <= '0;
                  end
               end
               start: begin
                  if (mid_start) begin
                     tick_cnt <= '0;
                     bit_cnt  <= '0;
                     state    <= rxd_sync ? idle : data;
                  end
               end
               data: begin
                  if (mid_bit) begin
                     shift   <= {rxd_sync, shift[7:1]};
                     bit_cnt <= bit_cnt + 3'd1;
                     if (bit_cnt == 3'd7) begin
                        state <= stop;
                     end
                  end
               end
               stop: begin
                  if (mid_bit) begin
                     rx_push              <= 1'b1;
                     rx_frame.data        <= shift;
                     rx_frame.frame_error <= !rxd_sync;
                     frame_error          <= !rxd_sync;
                     state                <= idle;
                  end
               end
               default: state <= idle;
            endcase
         end
      end
   end

endmodule

//--- uart_top.sv
`timescale 1ns/10ps

module uart_top #(
   parameter logic [7:0] base_address = 8'h00,
   parameter int         fifo_depth   = uart_pkg::fifo_depth
) (
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] port_id,
   input  logic [7:0] data_in,
   input  logic       read_strobe,
   input  logic       write_strobe,
   output logic [7:0] data_out,
   output logic       interrupt,
   input  logic       rxd,
   output logic       txd
);

   uart_pkg::status_t   status;
   uart_pkg::rx_frame_t rx_frame;
   uart_pkg::rx_frame_t rx_head;
   logic [7:0]          tx_wdata;
   logic [7:0]          tx_head;
   logic [15:0]         clock_divide;
   logic                tx_push;
   logic                tx_pop;
   logic                rx_push;
   logic                rx_pop;
   logic                tx_present;
   logic                tx_half;
   logic                tx_full;
   logic                rx_present;
   logic                rx_half;
   logic                rx_full;
   logic                frame_error;
   logic                enable;
   logic                tick;

   always_comb begin
      status.zero       = 2'b00;
      status.tx_full    = tx_full;
      status.tx_half    = tx_half;
      status.tx_present = tx_present;
      status.rx_full    = rx_full;
      status.rx_half    = rx_half;
      status.rx_present = rx_present;
   end

   uart_regs #(.base_address(base_address)) i_regs (
      .clk, .rst, .port_id, .data_in, .read_strobe, .write_strobe,
      .data_out, .interrupt, .tx_push, .tx_byte(tx_wdata), .rx_pop,
      .rx_head, .status, .frame_error, .enable, .clock_divide
   );

   uart_baud_timer i_baud_timer (
      .clk, .rst, .enable, .clock_divide, .tick
   );

   uart_fifo #(.payload_t(logic [7:0]), .depth(fifo_depth)) tx_fifo (
      .clk, .rst, .push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
      .rdata(tx_head), .present(tx_present), .half(tx_half), .full(tx_full)
   );

   uart_fifo #(.payload_t(uart_pkg::rx_frame_t), .depth(fifo_depth)) rx_fifo (
      .clk, .rst, .push(rx_push), .wdata(rx_frame), .pop(rx_pop),
      .rdata(rx_head), .present(rx_present), .half(rx_half), .full(rx_full)
   );

   uart_tx i_tx (
      .clk, .rst, .tick, .tx_present, .tx_byte(tx_head), .tx_pop, .txd
   );

   uart_rx i_rx (
      .clk, .rst, .tick, .enable, .rxd, .rx_push, .rx_frame, .frame_error
   );

endmodule

//--- tb_uart_top.sv
`timescale 1ns/10ps

module tb_uart_top;

   localparam logic [7:0] base         = 8'h40;
   localparam int         div_value    = 2;
   localparam int         bit_cycles   = uart_pkg::oversample * (div_value + 1);
   localparam int         frame_cycles = 10 * bit_cycles;
   // Eight serial frames in the run, with three frame times allowed for each.
   localparam int         frame_count     = 8;
   localparam int         watchdog_cycles = 3 * frame_count * frame_cycles;

   logic       clk;
   logic       rst;
   logic [7:0] port_id;
   logic [7:0] data_in;
   logic       read_strobe;
   logic       write_strobe;
   logic [7:0] data_out;
   logic       interrupt;
   logic       txd;
   logic       rxd;
   logic       bitbang_sel;
   logic       bitbang_rxd;
   int         errors;
   int         tests_run;
   int         tests_failed;
   int         test_start_errors;

   // The serial output loops back unless a test drives the line itself.
   assign rxd = bitbang_sel ? bitbang_rxd : txd;

   uart_top #(.base_address(base), .fifo_depth(uart_pkg::fifo_depth)) i_dut (
      .clk, .rst, .port_id, .data_in, .read_strobe, .write_strobe,
      .data_out, .interrupt, .rxd, .txd
   );

   always #10 clk = ~clk;

   initial begin
      #(watchdog_cycles * 20);
      $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
      $display("*** FAILED ***");
      $finish;
   end

   task automatic check_value(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
      assert (actual === expected) else begin
         $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
         errors++;
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic write_reg(input logic [7:0] offset, input logic [7:0] value);
      @(negedge clk);
      port_id      = base + offset;
      data_in      = value;
      write_strobe = 1'b1;
      @(negedge clk);
      write_strobe = 1'b0;
   endtask

   task automatic read_port(input logic [7:0] address, output logic [7:0] value);
      @(negedge clk);
      port_id     = address;
      read_strobe = 1'b1;
      @(negedge clk);
      read_strobe = 1'b0;
      value       = data_out;
   endtask

   task automatic read_reg(input logic [7:0] offset, output logic [7:0] value);
      read_port(base + offset, value);
   endtask

   task automatic wait_rx_present();
      uart_pkg::status_t status;
      int                polls;
      polls  = 0;
      status = '0;
      while (!status.rx_present && polls < 2 * frame_cycles) begin
         read_reg(uart_pkg::addr_status, status);
         polls++;
      end
      assert (status.rx_present) else begin
         $display("Error at %0t ns: no received frame appeared in the receive FIFO", $time);
         errors++;
      end
   endtask

   // Drives one frame on the serial line, LSB first, with a chosen stop level.
   task automatic send_serial(input logic [7:0] value, input logic stop_level);
      logic [9:0] frame;
      frame = {stop_level, value, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         bitbang_rxd = frame[i];
         repeat (bit_cycles - 1) @(negedge clk);
      end
      @(negedge clk);
      bitbang_rxd = 1'b1;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_start_errors) begin
         $display("Test %s: ok", name);
      end else begin
         tests_failed++;
         $display("Test %s: %0d check(s) failed", name, errors - test_start_errors);
      end
   endtask

   task automatic test_registers();
      logic [7:0] value;
      test_start_errors = errors;
      check_value("txd", txd, 1'b1);
      check_value("interrupt", interrupt, 1'b0);
      for (int offset = 0; offset <= 6; offset++) begin
         read_reg(offset, value);
         check_value($sformatf("register %0d after reset", offset), value, 8'h00);
      end
      write_reg(uart_pkg::addr_control, 8'ha4);
      write_reg(uart_pkg::addr_irq_mask, 8'h05);
      write_reg(uart_pkg::addr_div_lo, 8'h5a);
      write_reg(uart_pkg::addr_div_hi, 8'hc3);
      read_reg(uart_pkg::addr_control, value);
      check_value("control", value, 8'ha4);
      read_reg(uart_pkg::addr_irq_mask, value);
      check_value("irq_mask", value, 8'h05);
      read_reg(uart_pkg::addr_div_lo, value);
      check_value("div_lo", value, 8'h5a);
      read_reg(uart_pkg::addr_div_hi, value);
      check_value("div_hi", value, 8'hc3);
      read_port(base + 8'd7, value);
      check_value("unmapped base+7", value, 8'h00);
      read_port(8'h10, value);
      check_value("unmapped 0x10", value, 8'h00);
      write_reg(uart_pkg::addr_control, 8'h00);
      write_reg(uart_pkg::addr_irq_mask, 8'h00);
      write_reg(uart_pkg::addr_div_hi, 8'h00);
      end_test("registers");
   endtask

   task automatic test_single_byte();
      logic [7:0] sent;
      logic [7:0] value;
      test_start_errors = errors;
      write_reg(uart_pkg::addr_div_lo, 8'(div_value));
      write_reg(uart_pkg::addr_control, 8'h01);
      sent = 8'($urandom);
      write_reg(uart_pkg::addr_data, sent);
      wait_rx_present();
      read_reg(uart_pkg::addr_data, value);
      check_value("rx data", value, sent);
      read_reg(uart_pkg::addr_status, value);
      check_value("status", value, 8'h00);
      end_test("single byte loopback");
   endtask

   task automatic test_burst();
      logic [7:0]        sent [5];
      logic [7:0]        value;
      uart_pkg::status_t status;
      test_start_errors = errors;
      for (int i = 0; i < 5; i++) begin
         sent[i] = 8'($urandom);
         write_reg(uart_pkg::addr_data, sent[i]);
         read_reg(uart_pkg::addr_status, status);
         check_value("tx_present", status.tx_present, 1'b1);
         check_value("tx_half", status.tx_half, 1'b0);
      end
      for (int i = 0; i < 5; i++) begin
         wait_rx_present();
         read_reg(uart_pkg::addr_data, value);
         check_value($sformatf("rx data %0d", i), value, sent[i]);
      end
      read_reg(uart_pkg::addr_status, value);
      check_value("status", value, 8'h00);
      end_test("burst ordering");
   endtask

   task automatic test_interrupts();
      logic [7:0] sent;
      logic [7:0] value;
      test_start_errors = errors;
      write_reg(uart_pkg::addr_irq_mask, 8'h00);
      write_reg(uart_pkg::addr_irq, 8'h07);
      sent = 8'($urandom);
      write_reg(uart_pkg::addr_data, sent);
      wait_rx_present();
      wait_cycles(4);
      check_value("interrupt with mask 0", interrupt, 1'b0);
      read_reg(uart_pkg::addr_irq, value);
      check_value("irq pending", value, 8'h03);
      write_reg(uart_pkg::addr_irq_mask, 8'h01);
      wait_cycles(2);
      check_value("interrupt on rx_ready", interrupt, 1'b1);
      read_reg(uart_pkg::addr_data, value);
      check_value("rx data", value, sent);
      write_reg(uart_pkg::addr_irq, 8'h01);
      wait_cycles(2);
      check_value("interrupt after clear", interrupt, 1'b0);
      read_reg(uart_pkg::addr_irq, value);
      check_value("irq pending", value, 8'h02);
      write_reg(uart_pkg::addr_irq_mask, 8'h02);
      wait_cycles(2);
      check_value("interrupt on tx_empty", interrupt, 1'b1);
      write_reg(uart_pkg::addr_irq, 8'h02);
      wait_cycles(2);
      check_value("interrupt after tx_empty clear", interrupt, 1'b0);
      write_reg(uart_pkg::addr_irq_mask, 8'h00);
      end_test("interrupts");
   endtask

   task automatic test_frame_error();
      logic [7:0] sent;
      logic [7:0] value;
      test_start_errors = errors;
      write_reg(uart_pkg::addr_irq, 8'h07);
      @(negedge clk);
      bitbang_rxd = 1'b1;
      bitbang_sel = 1'b1;
      sent = 8'($urandom);
      send_serial(sent, 1'b0);
      wait_cycles(2 * bit_cycles);
      wait_rx_present();
      read_reg(uart_pkg::addr_data, value);
      check_value("rx data", value, sent);
      read_reg(uart_pkg::addr_irq, value);
      check_value("frame_error pending", value[2], 1'b1);
      write_reg(uart_pkg::addr_irq_mask, 8'h04);
      wait_cycles(2);
      check_value("interrupt on frame_error", interrupt, 1'b1);
      read_reg(uart_pkg::addr_status, value);
      check_value("status", value, 8'h00);
      write_reg(uart_pkg::addr_irq_mask, 8'h00);
      write_reg(uart_pkg::addr_irq, 8'h07);
      bitbang_sel = 1'b0;
      end_test("framing error");
   endtask

   initial begin
      int unsigned first_draw;
      first_draw   = $urandom(32'h3a6c);
      clk          = 1'b0;
      rst          = 1'b1;
      port_id      = 8'h00;
      data_in      = 8'h00;
      read_strobe  = 1'b0;
      write_strobe = 1'b0;
      bitbang_sel  = 1'b0;
      bitbang_rxd  = 1'b1;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (10) @(negedge clk);
      rst = 1'b0;
      test_registers();
      test_single_byte();
      test_burst();
      test_interrupts();
      test_frame_error();
      $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- project.f
uart_pkg.sv
uart_regs.sv
uart_baud_timer.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart_top.sv
